/* design/sap_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Global widths and control word bit map
// Include in any file that sizes a datapath or reads a control bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SAP_SETTINGS_SVH
`define SAP_SETTINGS_SVH

`define SAP_WORD_W      8
`define SAP_ADDR_W      4
`define SAP_RAM_DEPTH   16
`define SAP_CTRL_W      15

`define SIG_PC_INC          14  // Count PC
`define SIG_PC_EN           13  // PC onto bus
`define SIG_PC_LOAD         12  // Jump target into PC
`define SIG_MAR_ADDR_LOAD_N 11  // Address into MAR
`define SIG_MAR_MEM_LOAD_N  10  // Write data into staging reg
`define SIG_RAM_EN_N        9   // RAM onto bus
`define SIG_RAM_LOAD_N      8   // Staging reg into RAM
`define SIG_IR_LOAD_N       7
`define SIG_IR_EN_N         6   // IR operand onto bus
`define SIG_REGA_LOAD_N     5
`define SIG_REGA_EN         4
`define SIG_ADDER_SUB       3   // Subtract when high
`define SIG_REGB_EN         2   // ALU result onto bus
`define SIG_REGB_LOAD_N     1
`define SIG_OUT_LOAD_N      0

// Active-low bits high, everything else low
`define SAP_CTRL_IDLE 15'b000_1111_1110_0011

`endif

/* design/sap_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the accumulator machine
// Import with sap_pkg::* in the module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "sap_settings.svh"

package sap_pkg;

    typedef logic [`SAP_WORD_W-1:0] word_t;  // Bus and register width
    typedef logic [`SAP_ADDR_W-1:0] addr_t;  // RAM address and PC
    typedef logic [`SAP_CTRL_W-1:0] ctrl_t;  // One bit per micro-op control

    // Opcode lives in the high nibble of an instruction word
    typedef enum logic [3:0] {
        OP_HLT = 4'h0,
        OP_NOP = 4'h1,
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_LDA = 4'h4,
        OP_OUT = 4'h5,
        OP_STA = 4'h6,
        OP_JMP = 4'h7
    } opcode_t;

    typedef enum logic [2:0] {
        ST_T0   = 3'd0,  // Fetch address
        ST_T1   = 3'd1,  // PC increment
        ST_T2   = 3'd2,  // Fetch instruction
        ST_T3   = 3'd3,
        ST_T4   = 3'd4,
        ST_T5   = 3'd5,
        ST_HOLD = 3'd6   // Parked while in reset
    } stage_t;

endpackage

/* design/control_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction register, six-stage sequencer and micro-op decode
// Stage moves on the falling edge, loads happen on the rising edge
// OUT waits in T3 until the output register can take a word
// HLT parks the sequencer in T3 until the next reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module control_sequencer
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  word_t bus_data,
    input  logic  out_accept,
    output ctrl_t ctrl,
    output word_t ir_bus
);

    word_t   ir;
    opcode_t opcode;
    stage_t  stage;
    logic    out_loaded;  // Output load fired at the last rising edge

    assign opcode = opcode_t'(ir[7:4]);
    assign ir_bus = {4'b0000, ir[3:0]};  // Operand address only

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ir         <= '0;
            out_loaded <= 1'b0;
        end else begin
            if (!ctrl[`SIG_IR_LOAD_N]) begin
                ir <= bus_data;
            end
            out_loaded <= !ctrl[`SIG_OUT_LOAD_N];
        end
    end

    // Stage counter on the falling edge
    always_ff @(negedge clk) begin
        if (!resetn) begin
            stage <= ST_HOLD;
        end else begin
            case (stage)
                ST_HOLD: stage <= ST_T0;
                ST_T3: begin
                    if (opcode != OP_HLT && (opcode != OP_OUT || out_loaded)) begin
                        stage <= ST_T4;  // HLT parks here, OUT waits for its load
                    end
                end
                ST_T5:   stage <= ST_T0;
                default: stage <= stage_t'(stage + 3'd1);
            endcase
        end
    end

    always_comb begin
        ctrl = `SAP_CTRL_IDLE;
        case (stage)
            ST_T0: begin
                ctrl[`SIG_PC_EN]           = 1'b1;
                ctrl[`SIG_MAR_ADDR_LOAD_N] = 1'b0;
            end
            ST_T1: begin
                ctrl[`SIG_PC_INC] = 1'b1;  // IR still holds the previous word here
            end
            ST_T2: begin
                ctrl[`SIG_RAM_EN_N]  = 1'b0;
                ctrl[`SIG_IR_LOAD_N] = 1'b0;
            end
            ST_T3: begin
                case (opcode)
                    OP_ADD, OP_SUB, OP_LDA, OP_STA: begin
                        ctrl[`SIG_IR_EN_N]         = 1'b0;
                        ctrl[`SIG_MAR_ADDR_LOAD_N] = 1'b0;
                    end
                    OP_OUT: begin
                        ctrl[`SIG_REGA_EN]    = 1'b1;
                        ctrl[`SIG_OUT_LOAD_N] = !out_accept;  // Held off by back-pressure
                    end
                    OP_JMP: begin
                        ctrl[`SIG_IR_EN_N] = 1'b0;
                        ctrl[`SIG_PC_LOAD] = 1'b1;
                    end
                    default: ;
                endcase
            end
            ST_T4: begin
                case (opcode)
                    OP_ADD, OP_SUB: begin
                        ctrl[`SIG_RAM_EN_N]    = 1'b0;
                        ctrl[`SIG_REGB_LOAD_N] = 1'b0;
                    end
                    OP_LDA: begin
                        ctrl[`SIG_RAM_EN_N]    = 1'b0;
                        ctrl[`SIG_REGA_LOAD_N] = 1'b0;
                    end
                    OP_STA: begin
                        ctrl[`SIG_REGA_EN]        = 1'b1;
                        ctrl[`SIG_MAR_MEM_LOAD_N] = 1'b0;
                    end
                    default: ;
                endcase
            end
            ST_T5: begin
                case (opcode)
                    OP_ADD: begin
                        ctrl[`SIG_REGB_EN]     = 1'b1;
                        ctrl[`SIG_REGA_LOAD_N] = 1'b0;
                    end
                    OP_SUB: begin
                        ctrl[`SIG_ADDER_SUB]   = 1'b1;
                        ctrl[`SIG_REGB_EN]     = 1'b1;
                        ctrl[`SIG_REGA_LOAD_N] = 1'b0;
                    end
                    OP_STA:  ctrl[`SIG_RAM_LOAD_N] = 1'b0;
                    default: ;
                endcase
            end
            default: ;  // Hold stage keeps every control inactive
        endcase
    end

endmodule

/* design/program_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-bit program counter
// Counts, takes jump targets from the bus, drives itself onto the bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module program_counter
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  ctrl_t ctrl,
    input  word_t bus_data,
    output word_t pc_bus
);

    addr_t pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= '0;
        end else if (ctrl[`SIG_PC_LOAD]) begin
            pc <= bus_data[`SAP_ADDR_W-1:0];  // Jump target
        end else if (ctrl[`SIG_PC_INC]) begin
            pc <= pc + 1'b1;  // Wraps 15 to 0
        end
    end

    assign pc_bus = {{(`SAP_WORD_W-`SAP_ADDR_W){1'b0}}, pc};

endmodule

/* design/memory_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAR, write staging register and 16x8 RAM
// The program port fills the RAM only while resetn is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module memory_unit
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  ctrl_t ctrl,
    input  word_t bus_data,
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  word_t prog_data,
    output word_t ram_bus
);

    addr_t mar;
    word_t wr_data;  // Staged word for STA
    word_t mem [`SAP_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mar <= '0;
        end else if (!ctrl[`SIG_MAR_ADDR_LOAD_N]) begin
            mar <= bus_data[`SAP_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl[`SIG_MAR_MEM_LOAD_N]) begin
            wr_data <= bus_data;
        end
    end

    // Program load in reset, STA writes once running
    always_ff @(posedge clk) begin
        if (!resetn) begin
            if (prog_we) begin
                mem[prog_addr] <= prog_data;
            end
        end else if (!ctrl[`SIG_RAM_LOAD_N]) begin
            mem[mar] <= wr_data;
        end
    end

    assign ram_bus = mem[mar];  // Asynchronous read

endmodule

/* design/arith_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accumulator A, register B and the adder-subtractor
// A and the ALU result each have their own bus enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module arith_unit
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  ctrl_t ctrl,
    input  word_t bus_data,
    output word_t a_bus,
    output word_t alu_bus
);

    word_t reg_a;
    word_t reg_b;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_a <= '0;
            reg_b <= '0;
        end else begin
            if (!ctrl[`SIG_REGA_LOAD_N]) begin
                reg_a <= bus_data;  // LDA or ALU writeback
            end
            if (!ctrl[`SIG_REGB_LOAD_N]) begin
                reg_b <= bus_data;
            end
        end
    end

    // Result wraps modulo 256, no carry kept
    always_comb begin
        if (ctrl[`SIG_ADDER_SUB]) begin
            alu_bus = reg_a - reg_b;
        end else begin
            alu_bus = reg_a + reg_b;
        end
    end

    assign a_bus = reg_a;

endmodule

/* design/output_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output register with a valid/ready interface
// out_accept tells the sequencer a new word can be loaded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module output_port
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  ctrl_t ctrl,
    input  word_t bus_data,
    input  logic  out_ready,
    output word_t out_data,
    output logic  out_valid,
    output logic  out_accept
);

    logic load;

    assign load       = !ctrl[`SIG_OUT_LOAD_N];
    assign out_accept = !out_valid || out_ready;  // Empty, or draining this edge

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // Word taken, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= bus_data;
        end
    end

endmodule

/* design/bus_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared bus built as a gated OR of the sources
// Reads zero when no source is enabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module bus_mux
    import sap_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc_bus,
    input  word_t ir_bus,
    input  word_t a_bus,
    input  word_t alu_bus,
    input  word_t ram_bus,
    output word_t bus_data
);

    assign bus_data = ({`SAP_WORD_W{ctrl[`SIG_PC_EN]}}     & pc_bus)
                    | ({`SAP_WORD_W{!ctrl[`SIG_IR_EN_N]}}  & ir_bus)   // Active low
                    | ({`SAP_WORD_W{ctrl[`SIG_REGA_EN]}}   & a_bus)
                    | ({`SAP_WORD_W{ctrl[`SIG_REGB_EN]}}   & alu_bus)
                    | ({`SAP_WORD_W{!ctrl[`SIG_RAM_EN_N]}} & ram_bus); // Active low

endmodule

/* design/sap_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the accumulator machine
// Load a program during reset, then read results from the output port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sap_top
    import sap_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  word_t prog_data,
    input  logic  out_ready,
    output word_t out_data,
    output logic  out_valid
);

    ctrl_t ctrl;
    word_t bus_data;
    word_t pc_bus;
    word_t ir_bus;
    word_t a_bus;
    word_t alu_bus;
    word_t ram_bus;
    logic  out_accept;

    control_sequencer u_seq (
        .clk        (clk),
        .resetn     (resetn),
        .bus_data   (bus_data),
        .out_accept (out_accept),
        .ctrl       (ctrl),
        .ir_bus     (ir_bus)
    );

    program_counter u_pc (
        .clk      (clk),
        .resetn   (resetn),
        .ctrl     (ctrl),
        .bus_data (bus_data),
        .pc_bus   (pc_bus)
    );

    memory_unit u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (ctrl),
        .bus_data  (bus_data),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ram_bus   (ram_bus)
    );

    arith_unit u_alu (
        .clk      (clk),
        .resetn   (resetn),
        .ctrl     (ctrl),
        .bus_data (bus_data),
        .a_bus    (a_bus),
        .alu_bus  (alu_bus)
    );

    output_port u_out (
        .clk        (clk),
        .resetn     (resetn),
        .ctrl       (ctrl),
        .bus_data   (bus_data),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_accept (out_accept)
    );

    bus_mux u_bus (
        .ctrl     (ctrl),
        .pc_bus   (pc_bus),
        .ir_bus   (ir_bus),
        .a_bus    (a_bus),
        .alu_bus  (alu_bus),
        .ram_bus  (ram_bus),
        .bus_data (bus_data)
    );

endmodule

/* verification/sap_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the output handshake, bus and stage
// Bound into the sequencer and the output port below
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sap_settings.svh"

module sap_assert
    import sap_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input ctrl_t      ctrl,
    input logic [2:0] stage_bits,
    input logic       out_valid,
    input logic       out_ready,
    input word_t      out_data
);

    int         fail_count = 0;
    logic [4:0] bus_en;  // One bit per bus source

    assign bus_en = {ctrl[`SIG_PC_EN], !ctrl[`SIG_IR_EN_N], ctrl[`SIG_REGA_EN],
                     ctrl[`SIG_REGB_EN], !ctrl[`SIG_RAM_EN_N]};

    hold_until_taken: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_count++;
            $error("out_data or out_valid changed before the transfer");
        end

    single_bus_driver: assert property (@(posedge clk) disable iff (!resetn)
        $countones(bus_en) <= 1)
        else begin
            fail_count++;
            $error("more than one source drives the bus");
        end

    stage_in_range: assert property (@(posedge clk) disable iff (!resetn)
        stage_bits <= ST_HOLD)
        else begin
            fail_count++;
            $error("sequencer stage outside T0 to T5 and hold");
        end

endmodule

// Sequencer has no handshake, its handshake inputs sit idle
bind control_sequencer sap_assert seq_chk (
    .clk        (clk),
    .resetn     (resetn),
    .ctrl       (ctrl),
    .stage_bits (stage),
    .out_valid  (1'b0),
    .out_ready  (1'b1),
    .out_data   ('0)
);

bind output_port sap_assert out_chk (
    .clk        (clk),
    .resetn     (resetn),
    .ctrl       (ctrl),
    .stage_bits (3'd0),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
);

/* verification/sap_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the accumulator machine
// Loads programs through the program port during reset, predicts the
// output stream with an instruction-level model and checks each transfer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sap_tb
    import sap_pkg::*;
();

    typedef word_t word_q_t [$];

    localparam int NUM_RUNS       = 6;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * 64 * 6 * 4 + 200;  // 4x stall margin

    logic  clk       = 1'b0;
    logic  resetn    = 1'b0;
    logic  prog_we   = 1'b0;
    addr_t prog_addr = '0;
    word_t prog_data = '0;
    logic  out_ready = 1'b0;
    word_t out_data;
    logic  out_valid;

    word_t   prog [16];      // Image written at every reset
    word_q_t exp_q;          // Outputs still to come
    int      exp_total    = 0;
    string   test_name    = "none";
    logic    ready_random = 1'b0;
    int      low_left     = 0;  // Cycles left in a long not-ready stretch
    int      transfers    = 0;
    int      checked      = 0;
    int      errors       = 0;
    int      cycles       = 0;

    sap_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic word_t encode(input opcode_t op, input addr_t arg);
        return {op, arg};
    endfunction

    // Instruction-level view of the machine, B folded into the ALU step
    function automatic word_q_t sap_model(input word_t image [16]);
        word_t   mem [16];
        word_q_t outs;
        addr_t   pc;
        word_t   acc;
        word_t   ir;
        opcode_t op;
        addr_t   arg;
        mem = image;
        pc  = '0;
        acc = '0;
        for (int n = 0; n < 64; n++) begin
            ir  = mem[pc];
            op  = opcode_t'(ir[7:4]);
            arg = ir[3:0];
            if (op == OP_HLT) begin
                break;
            end
            pc = pc + 4'd1;  // Wraps like the hardware
            case (op)
                OP_ADD:  acc = acc + mem[arg];
                OP_SUB:  acc = acc - mem[arg];
                OP_LDA:  acc = mem[arg];
                OP_OUT:  outs.push_back(acc);
                OP_STA:  mem[arg] = acc;
                OP_JMP:  pc = arg;
                default: ;  // NOP and unused codes
            endcase
        end
        return outs;
    endfunction

    // NOPs below first_data, random operands from there up
    task automatic fill_prog(input int first_data);
        for (int k = 0; k < 16; k++) begin
            prog[k] = (k < first_data) ? encode(OP_NOP, 4'd0) : word_t'($urandom);
        end
    endtask

    task automatic build_arith_prog();
        fill_prog(12);
        prog[0] = encode(OP_LDA, 4'd12);
        prog[1] = encode(OP_ADD, 4'd13);
        prog[2] = encode(OP_OUT, 4'd0);
        prog[3] = encode(OP_SUB, 4'd14);
        prog[4] = encode(OP_OUT, 4'd0);
        prog[5] = encode(OP_SUB, 4'd15);
        prog[6] = encode(OP_OUT, 4'd0);
        prog[7] = encode(OP_ADD, 4'd12);
        prog[8] = encode(OP_OUT, 4'd0);
        prog[9] = encode(OP_HLT, 4'd0);
    endtask

    task automatic build_memory_prog();
        fill_prog(12);
        prog[0]  = encode(OP_LDA, 4'd13);
        prog[1]  = encode(OP_ADD, 4'd14);
        prog[2]  = encode(OP_STA, 4'd15);  // Overwrites a data word
        prog[3]  = encode(OP_LDA, 4'd13);
        prog[4]  = encode(OP_OUT, 4'd0);
        prog[5]  = encode(OP_LDA, 4'd15);
        prog[6]  = encode(OP_OUT, 4'd0);
        prog[7]  = encode(OP_SUB, 4'd13);
        prog[8]  = encode(OP_STA, 4'd12);
        prog[9]  = encode(OP_LDA, 4'd12);
        prog[10] = encode(OP_OUT, 4'd0);
        prog[11] = encode(OP_HLT, 4'd0);
    endtask

    task automatic build_jump_prog();
        fill_prog(13);
        prog[0] = encode(OP_LDA, 4'd14);
        prog[1] = encode(OP_OUT, 4'd0);
        prog[2] = encode(OP_JMP, 4'd5);
        prog[3] = encode(OP_LDA, 4'd15);  // Skipped
        prog[4] = encode(OP_OUT, 4'd0);   // Skipped
        prog[5] = encode(OP_ADD, 4'd13);
        prog[6] = encode(OP_OUT, 4'd0);
        prog[7] = encode(OP_HLT, 4'd0);
    endtask

    task automatic build_stream_prog();
        fill_prog(13);
        prog[0]  = encode(OP_LDA, 4'd15);
        prog[1]  = encode(OP_OUT, 4'd0);
        prog[2]  = encode(OP_ADD, 4'd14);
        prog[3]  = encode(OP_OUT, 4'd0);
        prog[4]  = encode(OP_OUT, 4'd0);  // Back-to-back OUT
        prog[5]  = encode(OP_SUB, 4'd13);
        prog[6]  = encode(OP_OUT, 4'd0);
        prog[7]  = encode(OP_ADD, 4'd15);
        prog[8]  = encode(OP_OUT, 4'd0);
        prog[9]  = encode(OP_ADD, 4'd14);
        prog[10] = encode(OP_OUT, 4'd0);
        prog[11] = encode(OP_OUT, 4'd0);
        prog[12] = encode(OP_HLT, 4'd0);
    endtask

    // Reset covers the 16 program writes and then 5 quiet cycles
    task automatic reset_and_load();
        @(posedge clk);
        resetn <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i);
            prog_data <= prog[i];
            @(posedge clk);
        end
        prog_we   <= 1'b0;
        exp_q     = sap_model(prog);
        exp_total = exp_q.size();
        repeat (5) begin
            @(posedge clk);
            check_value("reset out_valid", 32'd0, 32'(out_valid));
        end
        resetn <= 1'b1;
        @(posedge clk);
        check_value("reset release out_valid", 32'd0, 32'(out_valid));
    endtask

    // stop_after > 0 resets the machine again after that many outputs
    task automatic run_program(input string name, input int stop_after);
        int base;
        int target;
        reset_and_load();
        test_name = name;
        base      = transfers;
        target    = exp_total;
        if (stop_after > 0 && stop_after < exp_total) begin
            target = stop_after;
        end
        while (transfers - base < target) begin
            @(posedge clk);
        end
        if (target == exp_total) begin
            repeat (200) @(posedge clk);  // HLT must stay silent
            check_value({name, " count"}, exp_total, transfers - base);
        end
    endtask

    // Compare every transfer against the model queue
    always @(posedge clk) begin
        if (resetn && out_valid && out_ready) begin
            transfers++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: %s gave an output %0h beyond the expected list",
                         test_name, out_data);
            end else begin
                checked++;
                check_value(test_name, 32'(exp_q.pop_front()), 32'(out_data));
            end
        end
    end

    // Sink side, about 60% ready with occasional long stalls
    always @(posedge clk) begin
        if (!ready_random) begin
            out_ready <= 1'b1;
        end else if (low_left > 0) begin
            out_ready <= 1'b0;
            low_left  <= low_left - 1;
        end else if ($urandom_range(15, 0) == 0) begin
            out_ready <= 1'b0;
            low_left  <= $urandom_range(30, 8);
        end else begin
            out_ready <= ($urandom_range(99, 0) < 60);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run still busy after %0d cycles, stopped", TIMEOUT_CYCLES);
            $display("Summary: %0d values compared, %0d errors", checked, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h3a6e_4018));
        build_arith_prog();
        run_program("arith", 0);
        ready_random <= 1'b1;
        build_memory_prog();
        run_program("memory", 0);
        build_jump_prog();
        run_program("jump", 0);
        build_stream_prog();
        run_program("backpressure", 0);
        build_arith_prog();
        run_program("reset_mid", 2);
        run_program("reset_rerun", 0);  // Same image, starts again at 0
        check_value("assertion failures", 32'd0,
                    UUT.u_seq.seq_chk.fail_count + UUT.u_out.out_chk.fail_count);
        $display("Summary: %0d values compared, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/sap_pkg.sv
design/control_sequencer.sv
design/program_counter.sv
design/memory_unit.sv
design/arith_unit.sv
design/output_port.sv
design/bus_mux.sv
design/sap_top.sv
verification/sap_assert.sv
verification/sap_tb.sv

/* Makefile */
# Verilator build and run for the accumulator machine testbench

VERILATOR ?= verilator
TOP       ?= sap_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
